//--- list.f
hdl/cpu_pkg.sv
hdl/fetch_stage.sv
hdl/decode_stage.sv
hdl/register_file.sv
hdl/execute_stage.sv
hdl/memory_stage.sv
hdl/hazard_unit.sv
hdl/mips_cpu_harvard.sv
testbench/pipeline_checker.sv
testbench/tb_mips_cpu.sv

//--- testbench/tb_mips_cpu.sv
// Testbench for the pipelined MIPS32 subset core
// Directed and LFSR-generated programs checked against a sequential ISA model
`timescale 1ns/1ns

module tb_mips_cpu;

	localparam int          MAX_PROG_LEN    = 32;
	localparam int          NUM_RANDOM      = 24;
	localparam int          NUM_PROGRAMS    = NUM_RANDOM + 5;
	localparam int          HALT_LIMIT      = MAX_PROG_LEN * 4;
	localparam int          WATCHDOG_CYCLES = NUM_PROGRAMS * (HALT_LIMIT + 40) + 200;
	localparam logic [31:0] LFSR_SEED       = 32'h6ed4_da24;

	typedef struct packed {
		cpu_pkg::word_t addr;
		cpu_pkg::word_t data;
	} store_t;

	logic           clk;
	logic           arst_n;
	logic           active;
	logic           data_write;
	logic           data_read;
	cpu_pkg::word_t register_v0;
	cpu_pkg::word_t instr_address;
	cpu_pkg::word_t instr_readdata;
	cpu_pkg::word_t data_address;
	cpu_pkg::word_t data_writedata;
	cpu_pkg::word_t data_readdata;
	cpu_pkg::word_t fetch_index;

	cpu_pkg::word_t prog [0:MAX_PROG_LEN-1];
	cpu_pkg::word_t dmem [0:63];
	cpu_pkg::word_t model_regs [0:31];
	cpu_pkg::word_t model_mem [0:63];
	store_t         expected_stores [$];
	store_t         observed_stores [$];
	cpu_pkg::word_t expected_v0;
	logic [31:0]    lfsr_state = LFSR_SEED;
	int             error_count = 0;
	int             test_start = 0;
	int             tests_passed = 0;
	int             tests_failed = 0;

	mips_cpu_harvard uut (
		.clk            (clk),
		.arst_n         (arst_n),
		.active         (active),
		.register_v0    (register_v0),
		.instr_address  (instr_address),
		.instr_readdata (instr_readdata),
		.data_address   (data_address),
		.data_write     (data_write),
		.data_read      (data_read),
		.data_writedata (data_writedata),
		.data_readdata  (data_readdata)
	);

	// Instruction memory based at the reset vector, zero elsewhere
	assign fetch_index    = (instr_address - cpu_pkg::RESET_VECTOR) >> 2;
	assign instr_readdata = (fetch_index < MAX_PROG_LEN) ? prog[fetch_index[4:0]] : '0;
	assign data_readdata  = data_read ? dmem[data_address[7:2]] : '0;

	always @(posedge clk) begin
		if (data_write) begin
			dmem[data_address[7:2]] <= data_writedata;
			observed_stores.push_back({data_address, data_writedata});
		end
	end

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	function automatic logic [31:0] lfsr_step(input logic [31:0] state);
		return {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]};
	endfunction

	function automatic int unsigned take_bits(input int count);
		int unsigned value;
		value = 0;
		for (int i = 0; i < count; i++) begin
			lfsr_state = lfsr_step(lfsr_state);
			value = (value << 1) | lfsr_state[0];
		end
		return value;
	endfunction

	function automatic cpu_pkg::word_t fill_word(input cpu_pkg::word_t addr);
		return (addr * 32'h9e37_79b1) ^ {addr[15:0], ~addr[15:0]};
	endfunction

	function automatic cpu_pkg::word_t r_format(input cpu_pkg::funct_t funct,
			input cpu_pkg::reg_addr_t rd, input cpu_pkg::reg_addr_t rs,
			input cpu_pkg::reg_addr_t rt);
		return {cpu_pkg::OP_SPECIAL, rs, rt, rd, 5'd0, funct};
	endfunction

	function automatic cpu_pkg::word_t i_format(input cpu_pkg::opcode_t op,
			input cpu_pkg::reg_addr_t rt, input cpu_pkg::reg_addr_t rs, input logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	task automatic check_word(input string name, input cpu_pkg::word_t expected,
			input cpu_pkg::word_t actual);
		if (actual !== expected) begin
			error_count++;
			$display("FAILED %s: expected %h, actual %h", name, expected, actual);
		end
	endtask

	task automatic check_flag(input string name, input logic expected, input logic actual);
		if (actual !== expected) begin
			error_count++;
			$display("FAILED %s: expected %b, actual %b", name, expected, actual);
		end
	endtask

	task automatic check_count(input string name, input int expected, input int actual);
		if (actual != expected) begin
			error_count++;
			$display("FAILED %s: expected %0d, actual %0d", name, expected, actual);
		end
	endtask

	task automatic finish_test(input string name);
		if (error_count == test_start) begin
			tests_passed++;
			$display("test %s: ok", name);
		end else begin
			tests_failed++;
			$display("test %s: %0d mismatches", name, error_count - test_start);
		end
	endtask

	task automatic clear_program();
		for (int i = 0; i < MAX_PROG_LEN; i++) begin
			prog[i] = '0;
		end
	endtask

	// Reset for 8 cycles while both data memory copies get the fill pattern
	task automatic apply_reset();
		@(posedge clk);
		#1;
		arst_n = 1'b0;
		observed_stores.delete();
		for (int i = 0; i < 64; i++) begin
			dmem[i] <= fill_word(cpu_pkg::word_t'(i * 4));
			model_mem[i] = fill_word(cpu_pkg::word_t'(i * 4));
		end
		repeat (8) @(posedge clk);
		#1;
		arst_n = 1'b1;
	endtask

	// Sequential ISA model: no delay slot, register 0 reads zero
	task automatic run_model();
		int             idx;
		int             steps;
		logic           done;
		cpu_pkg::word_t instr;
		cpu_pkg::word_t a;
		cpu_pkg::word_t b;
		cpu_pkg::word_t imm_s;
		cpu_pkg::word_t addr;
		for (int i = 0; i < 32; i++) begin
			model_regs[i] = '0;
		end
		expected_stores.delete();
		idx = 0;
		steps = 0;
		done = 1'b0;
		while (!done && steps < HALT_LIMIT) begin
			instr = prog[idx];
			a = model_regs[instr[25:21]];
			b = model_regs[instr[20:16]];
			imm_s = {{16{instr[15]}}, instr[15:0]};
			addr = a + imm_s;
			idx++;
			case (instr[31:26])
				cpu_pkg::OP_SPECIAL: begin
					case (instr[5:0])
						cpu_pkg::FN_ADDU: model_regs[instr[15:11]] = a + b;
						cpu_pkg::FN_SUBU: model_regs[instr[15:11]] = a - b;
						cpu_pkg::FN_AND:  model_regs[instr[15:11]] = a & b;
						cpu_pkg::FN_OR:   model_regs[instr[15:11]] = a | b;
						cpu_pkg::FN_XOR:  model_regs[instr[15:11]] = a ^ b;
						cpu_pkg::FN_SLT:  model_regs[instr[15:11]] = ($signed(a) < $signed(b)) ? 1 : 0;
						cpu_pkg::FN_JR: begin
							done = (a == cpu_pkg::HALT_ADDRESS);
							idx = int'((a - cpu_pkg::RESET_VECTOR) >> 2);
						end
						default: ;
					endcase
				end
				cpu_pkg::OP_ADDIU: model_regs[instr[20:16]] = addr;
				cpu_pkg::OP_ORI:   model_regs[instr[20:16]] = a | {16'b0, instr[15:0]};
				cpu_pkg::OP_LW:    model_regs[instr[20:16]] = model_mem[addr[7:2]];
				cpu_pkg::OP_SW: begin
					expected_stores.push_back({addr, b});
					model_mem[addr[7:2]] = b;
				end
				cpu_pkg::OP_BEQ: idx = (a == b) ? idx + $signed(instr[15:0]) : idx;
				cpu_pkg::OP_BNE: idx = (a != b) ? idx + $signed(instr[15:0]) : idx;
				default: ;
			endcase
			model_regs[0] = '0;
			steps++;
		end
		expected_v0 = model_regs[2];
	endtask

	task automatic run_program(input string name);
		int cycles;
		int drained_count;
		test_start = error_count;
		apply_reset();
		run_model();
		cycles = 0;
		while (active && cycles < HALT_LIMIT) begin
			@(posedge clk);
			#1;
			cycles++;
		end
		if (active) begin
			error_count++;
			$display("%s: processor did not halt within %0d cycles", name, HALT_LIMIT);
		end
		repeat (5) @(posedge clk);
		#1;
		drained_count = observed_stores.size();
		repeat (5) @(posedge clk);
		#1;
		check_flag({name, " active"}, 1'b0, active);
		check_count({name, " stores after halt"}, drained_count, observed_stores.size());
		check_count({name, " store count"}, expected_stores.size(), observed_stores.size());
		for (int i = 0; i < expected_stores.size() && i < observed_stores.size(); i++) begin
			check_word($sformatf("%s store %0d address", name, i),
				expected_stores[i].addr, observed_stores[i].addr);
			check_word($sformatf("%s store %0d data", name, i),
				expected_stores[i].data, observed_stores[i].data);
		end
		check_word({name, " register_v0"}, expected_v0, register_v0);
		finish_test(name);
	endtask

	// Registers 1 to 7, loads and stores off $0, forward branches only
	task automatic generate_program();
		int                 body_len;
		int                 kind;
		int                 offset;
		cpu_pkg::reg_addr_t rd;
		cpu_pkg::reg_addr_t rs;
		cpu_pkg::reg_addr_t rt;
		clear_program();
		body_len = 12 + int'(take_bits(4));
		for (int i = 0; i < body_len; i++) begin
			kind = int'(take_bits(4));
			rd = cpu_pkg::reg_addr_t'(1 + take_bits(3) % 7);
			rs = cpu_pkg::reg_addr_t'(1 + take_bits(3) % 7);
			rt = cpu_pkg::reg_addr_t'(1 + take_bits(3) % 7);
			case (kind)
				0:       prog[i] = r_format(cpu_pkg::FN_ADDU, rd, rs, rt);
				1:       prog[i] = r_format(cpu_pkg::FN_SUBU, rd, rs, rt);
				2:       prog[i] = r_format(cpu_pkg::FN_AND, rd, rs, rt);
				3:       prog[i] = r_format(cpu_pkg::FN_OR, rd, rs, rt);
				4:       prog[i] = r_format(cpu_pkg::FN_XOR, rd, rs, rt);
				5:       prog[i] = r_format(cpu_pkg::FN_SLT, rd, rs, rt);
				6, 14:   prog[i] = i_format(cpu_pkg::OP_ADDIU, rt, rs, 16'(take_bits(16)));
				7, 15:   prog[i] = i_format(cpu_pkg::OP_ORI, rt, rs, 16'(take_bits(16)));
				8, 9:    prog[i] = i_format(cpu_pkg::OP_LW, rt, 5'd0, 16'(take_bits(6) << 2));
				10, 11:  prog[i] = i_format(cpu_pkg::OP_SW, rt, 5'd0, 16'(take_bits(6) << 2));
				default: begin
					offset = int'(take_bits(2));
					if (offset > body_len - i - 1) begin
						offset = body_len - i - 1;
					end
					prog[i] = i_format((kind == 12) ? cpu_pkg::OP_BEQ : cpu_pkg::OP_BNE,
						rt, rs, 16'(offset));
				end
			endcase
		end
		prog[body_len] = r_format(cpu_pkg::FN_JR, 5'd0, 5'd0, 5'd0);
	endtask

	task automatic reset_state_test();
		test_start = error_count;
		clear_program();
		apply_reset();
		check_flag("reset_state active", 1'b1, active);
		check_flag("reset_state data_write", 1'b0, data_write);
		check_flag("reset_state data_read", 1'b0, data_read);
		check_word("reset_state instr_address", cpu_pkg::RESET_VECTOR, instr_address);
		finish_test("reset_state");
	endtask

	task automatic forwarding_test();
		clear_program();
		prog[0]  = i_format(cpu_pkg::OP_ADDIU, 5'd1, 5'd0, 16'h0005);
		prog[1]  = i_format(cpu_pkg::OP_ORI, 5'd3, 5'd1, 16'h8001);
		prog[2]  = r_format(cpu_pkg::FN_ADDU, 5'd4, 5'd3, 5'd1);
		prog[3]  = r_format(cpu_pkg::FN_SUBU, 5'd5, 5'd1, 5'd4);
		prog[4]  = r_format(cpu_pkg::FN_SLT, 5'd6, 5'd5, 5'd1);
		prog[5]  = r_format(cpu_pkg::FN_XOR, 5'd7, 5'd5, 5'd6);
		prog[6]  = r_format(cpu_pkg::FN_AND, 5'd1, 5'd7, 5'd4);
		prog[7]  = r_format(cpu_pkg::FN_OR, 5'd2, 5'd1, 5'd7);
		prog[8]  = i_format(cpu_pkg::OP_ADDIU, 5'd2, 5'd2, 16'hfffd);
		prog[9]  = i_format(cpu_pkg::OP_SW, 5'd2, 5'd0, 16'h0008);
		prog[10] = r_format(cpu_pkg::FN_JR, 5'd0, 5'd0, 5'd0);
		run_program("forwarding");
	endtask

	task automatic load_use_test();
		clear_program();
		prog[0] = i_format(cpu_pkg::OP_ADDIU, 5'd1, 5'd0, 16'h1234);
		prog[1] = i_format(cpu_pkg::OP_SW, 5'd1, 5'd0, 16'h0004);
		prog[2] = i_format(cpu_pkg::OP_LW, 5'd3, 5'd0, 16'h0004);
		prog[3] = r_format(cpu_pkg::FN_ADDU, 5'd2, 5'd3, 5'd1);
		prog[4] = i_format(cpu_pkg::OP_SW, 5'd2, 5'd0, 16'h000c);
		prog[5] = i_format(cpu_pkg::OP_LW, 5'd4, 5'd0, 16'h0010);
		prog[6] = i_format(cpu_pkg::OP_SW, 5'd4, 5'd0, 16'h0014);
		prog[7] = i_format(cpu_pkg::OP_LW, 5'd5, 5'd0, 16'h0014);
		prog[8] = r_format(cpu_pkg::FN_SUBU, 5'd2, 5'd2, 5'd5);
		prog[9] = r_format(cpu_pkg::FN_JR, 5'd0, 5'd0, 5'd0);
		run_program("load_use");
	endtask

	// Each skipped SW sits right behind a taken branch
	task automatic branch_test();
		clear_program();
		prog[0]  = i_format(cpu_pkg::OP_ADDIU, 5'd1, 5'd0, 16'h0003);
		prog[1]  = i_format(cpu_pkg::OP_ADDIU, 5'd3, 5'd0, 16'h0003);
		prog[2]  = i_format(cpu_pkg::OP_BEQ, 5'd3, 5'd1, 16'h0001);
		prog[3]  = i_format(cpu_pkg::OP_SW, 5'd1, 5'd0, 16'h0000);
		prog[4]  = i_format(cpu_pkg::OP_ADDIU, 5'd2, 5'd0, 16'h0001);
		prog[5]  = i_format(cpu_pkg::OP_BNE, 5'd3, 5'd1, 16'h0001);
		prog[6]  = i_format(cpu_pkg::OP_ADDIU, 5'd2, 5'd2, 16'h0002);
		prog[7]  = i_format(cpu_pkg::OP_BNE, 5'd0, 5'd2, 16'h0001);
		prog[8]  = i_format(cpu_pkg::OP_SW, 5'd2, 5'd0, 16'h0004);
		prog[9]  = i_format(cpu_pkg::OP_LW, 5'd4, 5'd0, 16'h0008);
		prog[10] = i_format(cpu_pkg::OP_BEQ, 5'd4, 5'd4, 16'h0001);
		prog[11] = i_format(cpu_pkg::OP_SW, 5'd4, 5'd0, 16'h000c);
		prog[12] = i_format(cpu_pkg::OP_SW, 5'd2, 5'd0, 16'h0010);
		prog[13] = i_format(cpu_pkg::OP_BEQ, 5'd0, 5'd2, 16'h0001);
		prog[14] = i_format(cpu_pkg::OP_SW, 5'd1, 5'd0, 16'h0018);
		prog[15] = r_format(cpu_pkg::FN_JR, 5'd0, 5'd0, 5'd0);
		run_program("branches");
	endtask

	task automatic halt_test();
		clear_program();
		prog[0] = i_format(cpu_pkg::OP_ADDIU, 5'd2, 5'd0, 16'h0055);
		prog[1] = r_format(cpu_pkg::FN_JR, 5'd0, 5'd0, 5'd0);
		prog[2] = i_format(cpu_pkg::OP_SW, 5'd2, 5'd0, 16'h0000);
		prog[3] = i_format(cpu_pkg::OP_ADDIU, 5'd2, 5'd0, 16'h0001);
		run_program("halt");
	endtask

	initial begin
		arst_n = 1'b0;
		clear_program();
		reset_state_test();
		forwarding_test();
		load_use_test();
		branch_test();
		halt_test();
		for (int n = 0; n < NUM_RANDOM; n++) begin
			generate_program();
			run_program($sformatf("random_%0d", n));
		end
		$display("tests passed %0d, failed %0d, assertion failures %0d",
			tests_passed, tests_failed, uut.u_checker.failures);
		if (tests_failed == 0 && uut.u_checker.failures == 0) begin
			$display("TESTBENCH PASSED");
		end else begin
			$display("TESTBENCH FAILED");
		end
		$finish;
	end

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clk);
		$display("run timed out after %0d cycles", WATCHDOG_CYCLES);
		$display("TESTBENCH FAILED");
		$finish;
	end

endmodule

//--- testbench/pipeline_checker.sv
// Bus behavior assertions for the pipelined core, bound to its top level
`timescale 1ns/1ns

module pipeline_checker (
	input logic           clk,
	input logic           arst_n,
	input logic           active,
	input cpu_pkg::word_t instr_address,
	input logic           data_read,
	input logic           data_write
);

	int unsigned failures = 0;

	read_write_exclusive: assert property (@(posedge clk) disable iff (!arst_n)
		!(data_read && data_write))
	else begin
		failures++;
		$error("data_read and data_write high in the same cycle");
	end

	// Halt is sticky until the next reset
	active_stays_low: assert property (@(posedge clk) disable iff (!arst_n)
		!active |=> !active)
	else begin
		failures++;
		$error("active rose again after halt");
	end

	fetch_aligned: assert property (@(posedge clk) disable iff (!arst_n)
		active |-> (instr_address[1:0] == 2'b00))
	else begin
		failures++;
		$error("instr_address not word aligned: %h", instr_address);
	end

	no_write_in_reset: assert property (@(posedge clk) !arst_n |-> !data_write)
	else begin
		failures++;
		$error("data_write high during reset");
	end

endmodule

bind mips_cpu_harvard pipeline_checker u_checker (
	.clk           (clk),
	.arst_n        (arst_n),
	.active        (active),
	.instr_address (instr_address),
	.data_read     (data_read),
	.data_write    (data_write)
);

//--- hdl/mips_cpu_harvard.sv
// Five-stage pipelined MIPS32 subset core with separate instruction and data buses
// Combinational reads on both buses, single-cycle data writes
`timescale 1ns/1ns

module mips_cpu_harvard (
	input  logic           clk,
	input  logic           arst_n,
	output logic           active,
	output cpu_pkg::word_t register_v0,

	output cpu_pkg::word_t instr_address,
	input  cpu_pkg::word_t instr_readdata,

	output cpu_pkg::word_t data_address,
	output logic           data_write,
	output logic           data_read,
	output cpu_pkg::word_t data_writedata,
	input  cpu_pkg::word_t data_readdata
);

	// Fetch to decode
	cpu_pkg::word_t     instr_decode;
	cpu_pkg::word_t     pc_plus4_decode;
	logic               redirect;
	cpu_pkg::word_t     redirect_target;

	// Decode
	cpu_pkg::reg_addr_t rs_decode;
	cpu_pkg::reg_addr_t rt_decode;
	logic               branch_use;
	cpu_pkg::word_t     rf_data_a;
	cpu_pkg::word_t     rf_data_b;
	cpu_pkg::id_ex_t    id_ex;

	// Execute, memory, writeback
	cpu_pkg::ex_mem_t   ex_mem;
	cpu_pkg::reg_addr_t dest_execute;
	cpu_pkg::mem_wb_t   mem_wb;
	cpu_pkg::word_t     wb_result;

	// Hazard controls
	logic               stall;
	logic               flush_ex;
	logic               fwd_branch_a;
	logic               fwd_branch_b;
	cpu_pkg::fwd_sel_e  fwd_a;
	cpu_pkg::fwd_sel_e  fwd_b;

	// Data bus is driven straight from the execute/memory register
	assign data_address   = ex_mem.alu_result;
	assign data_writedata = ex_mem.store_data;
	assign data_write     = ex_mem.mem_write;
	assign data_read      = ex_mem.mem_to_reg;

	fetch_stage u_fetch (
		.clk             (clk),
		.arst_n          (arst_n),
		.stall           (stall),
		.redirect        (redirect),
		.redirect_target (redirect_target),
		.instr_readdata  (instr_readdata),
		.pc              (instr_address),
		.instr_decode    (instr_decode),
		.pc_plus4_decode (pc_plus4_decode),
		.active          (active)
	);

	decode_stage u_decode (
		.clk             (clk),
		.arst_n          (arst_n),
		.instr           (instr_decode),
		.pc_plus4        (pc_plus4_decode),
		.rf_data_a       (rf_data_a),
		.rf_data_b       (rf_data_b),
		.mem_alu_result  (ex_mem.alu_result),
		.fwd_branch_a    (fwd_branch_a),
		.fwd_branch_b    (fwd_branch_b),
		.flush_ex        (flush_ex),
		.rs              (rs_decode),
		.rt              (rt_decode),
		.branch_use      (branch_use),
		.redirect        (redirect),
		.redirect_target (redirect_target),
		.id_ex           (id_ex)
	);

	register_file u_regs (
		.clk          (clk),
		.arst_n       (arst_n),
		.read_addr_a  (rs_decode),
		.read_addr_b  (rt_decode),
		.write_enable (mem_wb.reg_write),
		.write_addr   (mem_wb.dest),
		.write_data   (wb_result),
		.read_data_a  (rf_data_a),
		.read_data_b  (rf_data_b),
		.register_v0  (register_v0)
	);

	execute_stage u_execute (
		.clk       (clk),
		.arst_n    (arst_n),
		.id_ex     (id_ex),
		.fwd_a     (fwd_a),
		.fwd_b     (fwd_b),
		.wb_result (wb_result),
		.ex_mem    (ex_mem),
		.dest      (dest_execute)
	);

	memory_stage u_memory (
		.clk           (clk),
		.arst_n        (arst_n),
		.ex_mem        (ex_mem),
		.data_readdata (data_readdata),
		.mem_wb        (mem_wb),
		.result        (wb_result)
	);

	hazard_unit u_hazard (
		.rs_decode    (rs_decode),
		.rt_decode    (rt_decode),
		.branch_use   (branch_use),
		.id_ex        (id_ex),
		.dest_execute (dest_execute),
		.ex_mem       (ex_mem),
		.mem_wb       (mem_wb),
		.stall        (stall),
		.flush_ex     (flush_ex),
		.fwd_branch_a (fwd_branch_a),
		.fwd_branch_b (fwd_branch_b),
		.fwd_a        (fwd_a),
		.fwd_b        (fwd_b)
	);

endmodule

//--- hdl/hazard_unit.sv
// Hazard unit: execute and branch forwarding selects, load-use and branch stalls
`timescale 1ns/1ns

module hazard_unit (
	input  cpu_pkg::reg_addr_t rs_decode,
	input  cpu_pkg::reg_addr_t rt_decode,
	input  logic               branch_use,
	input  cpu_pkg::id_ex_t    id_ex,
	input  cpu_pkg::reg_addr_t dest_execute,
	input  cpu_pkg::ex_mem_t   ex_mem,
	input  cpu_pkg::mem_wb_t   mem_wb,
	output logic               stall,
	output logic               flush_ex,
	output logic               fwd_branch_a,
	output logic               fwd_branch_b,
	output cpu_pkg::fwd_sel_e  fwd_a,
	output cpu_pkg::fwd_sel_e  fwd_b
);

	logic decode_hits_ex;
	logic load_use;
	logic branch_stall;

	// Register 0 never carries a dependency
	function automatic logic hits(input cpu_pkg::reg_addr_t dest, input cpu_pkg::reg_addr_t src);
		return (dest != '0) && (dest == src);
	endfunction

	// Memory stage is newer than writeback, so it wins
	function automatic cpu_pkg::fwd_sel_e forward_sel(
		input cpu_pkg::reg_addr_t src,
		input cpu_pkg::ex_mem_t   mem,
		input cpu_pkg::mem_wb_t   wb
	);
		if (mem.reg_write && hits(mem.dest, src)) begin
			return cpu_pkg::FWD_MEMORY;
		end else if (wb.reg_write && hits(wb.dest, src)) begin
			return cpu_pkg::FWD_WRITEBACK;
		end
		return cpu_pkg::FWD_NONE;
	endfunction

	assign fwd_a = forward_sel(id_ex.rs, ex_mem, mem_wb);
	assign fwd_b = forward_sel(id_ex.rt, ex_mem, mem_wb);

	// Only an ALU result in memory is usable for a compare
	assign fwd_branch_a = ex_mem.reg_write && !ex_mem.mem_to_reg && hits(ex_mem.dest, rs_decode);
	assign fwd_branch_b = ex_mem.reg_write && !ex_mem.mem_to_reg && hits(ex_mem.dest, rt_decode);

	assign decode_hits_ex = hits(dest_execute, rs_decode) || hits(dest_execute, rt_decode);
	assign load_use       = id_ex.ctrl.mem_to_reg && decode_hits_ex;

	assign branch_stall = branch_use &&
		((id_ex.ctrl.reg_write && decode_hits_ex) ||
		 (ex_mem.reg_write && ex_mem.mem_to_reg &&
		  (hits(ex_mem.dest, rs_decode) || hits(ex_mem.dest, rt_decode))));

	assign stall    = load_use || branch_stall;
	assign flush_ex = stall;

endmodule

//--- hdl/memory_stage.sv
// Memory stage: captures load data into the memory/writeback register
// and selects the value written back
`timescale 1ns/1ns

module memory_stage (
	input  logic             clk,
	input  logic             arst_n,
	input  cpu_pkg::ex_mem_t ex_mem,
	input  cpu_pkg::word_t   data_readdata,
	output cpu_pkg::mem_wb_t mem_wb,
	output cpu_pkg::word_t   result
);

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			mem_wb <= '0;
		end else begin
			mem_wb.reg_write  <= ex_mem.reg_write;
			mem_wb.mem_to_reg <= ex_mem.mem_to_reg;
			mem_wb.alu_result <= ex_mem.alu_result;
			mem_wb.load_data  <= data_readdata;
			mem_wb.dest       <= ex_mem.dest;
		end
	end

	// Also feeds execute as the writeback forwarding source
	assign result = mem_wb.mem_to_reg ? mem_wb.load_data : mem_wb.alu_result;

endmodule

//--- hdl/execute_stage.sv
// Execute stage: operand forwarding, ALU and destination select
// feeding the execute/memory pipeline register
`timescale 1ns/1ns

module execute_stage (
	input  logic                clk,
	input  logic                arst_n,
	input  cpu_pkg::id_ex_t     id_ex,
	input  cpu_pkg::fwd_sel_e   fwd_a,
	input  cpu_pkg::fwd_sel_e   fwd_b,
	input  cpu_pkg::word_t      wb_result,
	output cpu_pkg::ex_mem_t    ex_mem,
	output cpu_pkg::reg_addr_t  dest
);

	cpu_pkg::word_t operand_a;
	cpu_pkg::word_t reg_b;
	cpu_pkg::word_t operand_b;
	cpu_pkg::word_t alu_result;

	function automatic cpu_pkg::word_t forward_mux(
		input cpu_pkg::fwd_sel_e sel,
		input cpu_pkg::word_t    reg_value,
		input cpu_pkg::word_t    mem_value,
		input cpu_pkg::word_t    wb_value
	);
		case (sel)
			cpu_pkg::FWD_MEMORY:    return mem_value;
			cpu_pkg::FWD_WRITEBACK: return wb_value;
			default:                return reg_value;
		endcase
	endfunction

	assign operand_a = forward_mux(fwd_a, id_ex.src_a, ex_mem.alu_result, wb_result);
	assign reg_b     = forward_mux(fwd_b, id_ex.src_b, ex_mem.alu_result, wb_result);
	assign operand_b = id_ex.ctrl.alu_src_imm ? id_ex.imm : reg_b;

	always_comb begin
		case (id_ex.ctrl.alu_op)
			cpu_pkg::ALU_SUB: alu_result = operand_a - operand_b;
			cpu_pkg::ALU_AND: alu_result = operand_a & operand_b;
			cpu_pkg::ALU_OR:  alu_result = operand_a | operand_b;
			cpu_pkg::ALU_XOR: alu_result = operand_a ^ operand_b;
			cpu_pkg::ALU_SLT: alu_result = {31'b0, $signed(operand_a) < $signed(operand_b)};
			default:          alu_result = operand_a + operand_b;
		endcase
	end

	// R-type writes rd, I-type writes rt
	assign dest = id_ex.ctrl.reg_dst_rd ? id_ex.rd : id_ex.rt;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			ex_mem <= '0;
		end else begin
			ex_mem.reg_write  <= id_ex.ctrl.reg_write;
			ex_mem.mem_to_reg <= id_ex.ctrl.mem_to_reg;
			ex_mem.mem_write  <= id_ex.ctrl.mem_write;
			ex_mem.alu_result <= alu_result;
			ex_mem.store_data <= reg_b;
			ex_mem.dest       <= dest;
		end
	end

endmodule

//--- hdl/register_file.sv
// General purpose register file, 31 writable registers plus a hardwired zero
// Writes in the same cycle are visible on the read ports
`timescale 1ns/1ns

module register_file (
	input  logic               clk,
	input  logic               arst_n,
	input  cpu_pkg::reg_addr_t read_addr_a,
	input  cpu_pkg::reg_addr_t read_addr_b,
	input  logic               write_enable,
	input  cpu_pkg::reg_addr_t write_addr,
	input  cpu_pkg::word_t     write_data,
	output cpu_pkg::word_t     read_data_a,
	output cpu_pkg::word_t     read_data_b,
	output cpu_pkg::word_t     register_v0
);

	cpu_pkg::word_t regs [1:31];

	function automatic cpu_pkg::word_t read_port(input cpu_pkg::reg_addr_t addr);
		if (addr == '0) begin
			return '0;
		end else if (write_enable && (write_addr == addr)) begin
			return write_data;
		end
		return regs[addr];
	endfunction

	always_comb begin
		read_data_a = read_port(read_addr_a);
		read_data_b = read_port(read_addr_b);
	end

	assign register_v0 = regs[cpu_pkg::V0_INDEX];

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 1; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (write_enable && (write_addr != '0)) begin
			regs[write_addr] <= write_data;
		end
	end

endmodule

//--- hdl/decode_stage.sv
// Decode stage: control decode, immediate extension, branch and JR resolution
// and the decode/execute pipeline register
`timescale 1ns/1ns

module decode_stage (
	input  logic               clk,
	input  logic               arst_n,
	input  cpu_pkg::word_t     instr,
	input  cpu_pkg::word_t     pc_plus4,
	input  cpu_pkg::word_t     rf_data_a,
	input  cpu_pkg::word_t     rf_data_b,
	input  cpu_pkg::word_t     mem_alu_result,
	input  logic               fwd_branch_a,
	input  logic               fwd_branch_b,
	input  logic               flush_ex,
	output cpu_pkg::reg_addr_t rs,
	output cpu_pkg::reg_addr_t rt,
	output logic               branch_use,
	output logic               redirect,
	output cpu_pkg::word_t     redirect_target,
	output cpu_pkg::id_ex_t    id_ex
);

	cpu_pkg::opcode_t   opcode;
	cpu_pkg::funct_t    funct;
	cpu_pkg::reg_addr_t rd;
	cpu_pkg::ctrl_t     ctrl;
	cpu_pkg::word_t     imm_ext;
	cpu_pkg::word_t     cmp_a;
	cpu_pkg::word_t     cmp_b;
	cpu_pkg::word_t     branch_target;
	logic               is_beq;
	logic               is_bne;
	logic               is_jr;
	logic               taken;

	assign opcode = instr[31:26];
	assign rs     = instr[25:21];
	assign rt     = instr[20:16];
	assign rd     = instr[15:11];
	assign funct  = instr[5:0];

	assign is_beq     = (opcode == cpu_pkg::OP_BEQ);
	assign is_bne     = (opcode == cpu_pkg::OP_BNE);
	assign is_jr      = (opcode == cpu_pkg::OP_SPECIAL) && (funct == cpu_pkg::FN_JR);
	assign branch_use = is_beq || is_bne || is_jr;

	// Unlisted encodings fall through with all controls low
	always_comb begin
		ctrl        = '0;
		ctrl.alu_op = cpu_pkg::ALU_ADD;
		case (opcode)
			cpu_pkg::OP_SPECIAL: begin
				ctrl.reg_write  = 1'b1;
				ctrl.reg_dst_rd = 1'b1;
				case (funct)
					cpu_pkg::FN_ADDU: ctrl.alu_op = cpu_pkg::ALU_ADD;
					cpu_pkg::FN_SUBU: ctrl.alu_op = cpu_pkg::ALU_SUB;
					cpu_pkg::FN_AND:  ctrl.alu_op = cpu_pkg::ALU_AND;
					cpu_pkg::FN_OR:   ctrl.alu_op = cpu_pkg::ALU_OR;
					cpu_pkg::FN_XOR:  ctrl.alu_op = cpu_pkg::ALU_XOR;
					cpu_pkg::FN_SLT:  ctrl.alu_op = cpu_pkg::ALU_SLT;
					default: begin
						ctrl.reg_write  = 1'b0;
						ctrl.reg_dst_rd = 1'b0;
					end
				endcase
			end
			cpu_pkg::OP_ADDIU: begin
				ctrl.reg_write   = 1'b1;
				ctrl.alu_src_imm = 1'b1;
			end
			cpu_pkg::OP_ORI: begin
				ctrl.reg_write   = 1'b1;
				ctrl.alu_src_imm = 1'b1;
				ctrl.alu_op      = cpu_pkg::ALU_OR;
			end
			cpu_pkg::OP_LW: begin
				ctrl.reg_write   = 1'b1;
				ctrl.mem_to_reg  = 1'b1;
				ctrl.alu_src_imm = 1'b1;
			end
			cpu_pkg::OP_SW: begin
				ctrl.mem_write   = 1'b1;
				ctrl.alu_src_imm = 1'b1;
			end
			default: ;
		endcase
	end

	// ORI is the only zero-extended immediate
	assign imm_ext = (opcode == cpu_pkg::OP_ORI) ? {16'b0, instr[15:0]}
	                                             : {{16{instr[15]}}, instr[15:0]};

	assign cmp_a = fwd_branch_a ? mem_alu_result : rf_data_a;
	assign cmp_b = fwd_branch_b ? mem_alu_result : rf_data_b;

	assign branch_target   = pc_plus4 + {imm_ext[29:0], 2'b00};
	assign taken           = (is_beq && (cmp_a == cmp_b)) || (is_bne && (cmp_a != cmp_b)) || is_jr;
	// Operands are not valid yet while the hazard unit holds decode
	assign redirect        = taken && !flush_ex;
	assign redirect_target = is_jr ? cmp_a : branch_target;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			id_ex <= '0;
		end else if (flush_ex) begin
			id_ex <= '0;
		end else begin
			id_ex.ctrl  <= ctrl;
			id_ex.src_a <= rf_data_a;
			id_ex.src_b <= rf_data_b;
			id_ex.imm   <= imm_ext;
			id_ex.rs    <= rs;
			id_ex.rt    <= rt;
			id_ex.rd    <= rd;
		end
	end

endmodule

//--- hdl/fetch_stage.sv
// Fetch stage: program counter, halt detection at address zero
// and the fetch/decode pipeline register
`timescale 1ns/1ns

module fetch_stage (
	input  logic           clk,
	input  logic           arst_n,
	input  logic           stall,
	input  logic           redirect,
	input  cpu_pkg::word_t redirect_target,
	input  cpu_pkg::word_t instr_readdata,
	output cpu_pkg::word_t pc,
	output cpu_pkg::word_t instr_decode,
	output cpu_pkg::word_t pc_plus4_decode,
	output logic           active
);

	logic           halted;
	logic           at_halt;
	cpu_pkg::word_t pc_plus4;

	assign pc_plus4 = pc + 32'd4;
	assign at_halt  = (pc == cpu_pkg::HALT_ADDRESS);
	assign active   = !halted;

	// PC freezes once it reaches the halt address
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			pc     <= cpu_pkg::RESET_VECTOR;
			halted <= 1'b0;
		end else if (at_halt) begin
			halted <= 1'b1;
		end else if (redirect) begin
			pc <= redirect_target;
		end else if (!stall) begin
			pc <= pc_plus4;
		end
	end

	// Zero word decodes as sll $0,$0,0, a no-op here
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			instr_decode <= '0;
		end else if (redirect) begin
			instr_decode <= '0;
		end else if (!stall) begin
			instr_decode <= at_halt ? '0 : instr_readdata;
		end
	end

	always_ff @(posedge clk) begin
		if (!stall) begin
			pc_plus4_decode <= pc_plus4;
		end
	end

endmodule

//--- hdl/cpu_pkg.sv
// Shared definitions for the five-stage MIPS32 subset pipeline
// Widths, instruction encodings, ALU and forwarding selects, pipeline registers

package cpu_pkg;

	localparam int WORD_W     = 32;
	localparam int REG_ADDR_W = 5;

	typedef logic [WORD_W-1:0]     word_t;
	typedef logic [REG_ADDR_W-1:0] reg_addr_t;
	typedef logic [5:0]            opcode_t;
	typedef logic [5:0]            funct_t;

	localparam word_t     RESET_VECTOR = 32'hBFC0_0000;
	localparam word_t     HALT_ADDRESS = 32'h0000_0000;
	localparam reg_addr_t V0_INDEX     = 5'd2;

	// Primary opcodes
	localparam opcode_t OP_SPECIAL = 6'h00;
	localparam opcode_t OP_ADDIU   = 6'h09;
	localparam opcode_t OP_ORI     = 6'h0D;
	localparam opcode_t OP_LW      = 6'h23;
	localparam opcode_t OP_SW      = 6'h2B;
	localparam opcode_t OP_BEQ     = 6'h04;
	localparam opcode_t OP_BNE     = 6'h05;

	// SPECIAL funct codes
	localparam funct_t FN_ADDU = 6'h21;
	localparam funct_t FN_SUBU = 6'h23;
	localparam funct_t FN_AND  = 6'h24;
	localparam funct_t FN_OR   = 6'h25;
	localparam funct_t FN_XOR  = 6'h26;
	localparam funct_t FN_SLT  = 6'h2A;
	localparam funct_t FN_JR   = 6'h08;

	typedef enum logic [2:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_XOR,
		ALU_SLT
	} alu_op_e;

	typedef enum logic [1:0] {
		FWD_NONE,
		FWD_MEMORY,
		FWD_WRITEBACK
	} fwd_sel_e;

	typedef struct packed {
		logic    reg_write;
		logic    mem_to_reg;
		logic    mem_write;
		logic    alu_src_imm;
		logic    reg_dst_rd;
		alu_op_e alu_op;
	} ctrl_t;

	typedef struct packed {
		ctrl_t     ctrl;
		word_t     src_a;
		word_t     src_b;
		word_t     imm;
		reg_addr_t rs;
		reg_addr_t rt;
		reg_addr_t rd;
	} id_ex_t;

	typedef struct packed {
		logic      reg_write;
		logic      mem_to_reg;
		logic      mem_write;
		word_t     alu_result;
		word_t     store_data;
		reg_addr_t dest;
	} ex_mem_t;

	typedef struct packed {
		logic      reg_write;
		logic      mem_to_reg;
		word_t     alu_result;
		word_t     load_data;
		reg_addr_t dest;
	} mem_wb_t;

endpackage
